//--- Bender.yml
package:
  name: periph_bus

sources:
  - logic/periph_pkg.sv
  - logic/periph_decode.sv
  - logic/gpio_ctrl.sv
  - logic/read_return_fsm.sv
  - logic/periph_bus_top.sv
  - target: test
    files:
      - tests/periph_bus_tb.sv

//--- flist.f
logic/periph_pkg.sv
logic/periph_decode.sv
logic/gpio_ctrl.sv
logic/read_return_fsm.sv
logic/periph_bus_top.sv
tests/periph_bus_tb.sv

//--- logic/gpio_ctrl.sv
// GPIO output register, pin function selects, GPIO read mux and output pin mux
module gpio_ctrl
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  gpio_req_t         i_req,
    input  logic [PIN_W-1:0]  i_ui_in,
    output logic [DATA_W-1:0] o_rdata,
    output logic [PIN_W-1:0]  o_uo_out
);

    localparam int IDX_W = $clog2(PIN_W);

    logic [PIN_W-1:0]  out_q;
    logic [FSEL_W-1:0] fsel_q [PIN_W];

    logic             out_hit;
    logic             in_hit;
    logic             fsel_hit;
    logic [IDX_W-1:0] fsel_idx;

    // Offset decode
    assign out_hit  = (i_req.offset == GPIO_OUT_OFS);
    assign in_hit   = (i_req.offset == GPIO_IN_OFS);
    // Selects are word aligned from FSEL_BASE, bits 4:2 give the pin
    assign fsel_hit = ((i_req.offset & ~6'h1C) == FSEL_BASE);
    assign fsel_idx = i_req.offset[IDX_W+1:2];

    // Output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (i_req.wr && out_hit) begin
            out_q <= i_req.wdata[PIN_W-1:0];
        end
    end

    // Pin function selects
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PIN_W; i++) begin
                // Pins 0 and 1 default to the old UART function
                if (i < 2) begin
                    fsel_q[i] <= FSEL_W'(UART_SLOT);
                end else begin
                    fsel_q[i] <= FSEL_W'(GPIO_SLOT);
                end
            end
        end else if (i_req.wr && fsel_hit) begin
            fsel_q[fsel_idx] <= i_req.wdata[FSEL_W-1:0];
        end
    end

    // Read mux
    always_comb begin
        o_rdata = '0;
        if (out_hit) begin
            o_rdata[PIN_W-1:0] = out_q;
        end else if (in_hit) begin
            o_rdata[PIN_W-1:0] = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[FSEL_W-1:0] = fsel_q[fsel_idx];
        end
    end

    // Output pin mux
    always_comb begin
        for (int i = 0; i < PIN_W; i++) begin
            o_uo_out[i] = 1'b0;
            if (fsel_q[i][FSEL_W-1]) begin
                // Simple space function, nothing there
                o_uo_out[i] = 1'b0;
            end else if (fsel_q[i][FSEL_W-2:0] == (FSEL_W-1)'(GPIO_SLOT)) begin
                o_uo_out[i] = out_q[i];
            end
        end
    end

endmodule

//--- logic/periph_bus_top.sv
// Peripheral bus wrapper top level connecting decode, GPIO and read return
module periph_bus_top
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Pins
    input  logic [PIN_W-1:0]  i_ui_in,
    output logic [PIN_W-1:0]  o_uo_out,

    // Core side
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  access_size_e      i_data_write_n,
    input  access_size_e      i_data_read_n,
    input  logic              i_data_read_complete,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready
);

    bus_req_t          bus_req;
    gpio_req_t         gpio_req;
    read_rsp_t         slot_rsp;
    logic [DATA_W-1:0] gpio_rdata;

    // Core request as one struct
    assign bus_req.addr       = i_addr;
    assign bus_req.wdata      = i_data;
    assign bus_req.write_size = i_data_write_n;
    assign bus_req.read_size  = i_data_read_n;

    periph_decode i_decode (
        .i_req        (bus_req),
        .i_gpio_rdata (gpio_rdata),
        .o_gpio_req   (gpio_req),
        .o_rsp        (slot_rsp)
    );

    gpio_ctrl i_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_req    (gpio_req),
        .i_ui_in  (i_ui_in),
        .o_rdata  (gpio_rdata),
        .o_uo_out (o_uo_out)
    );

    read_return_fsm i_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_rsp           (slot_rsp),
        .i_read_size     (bus_req.read_size),
        .i_write_size    (bus_req.write_size),
        .i_read_complete (i_data_read_complete),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

endmodule

//--- logic/periph_decode.sv
// Address decode with GPIO write gating and per-slot read response multiplexer
module periph_decode
    import periph_pkg::*;
(
    input  bus_req_t          i_req,
    input  logic [DATA_W-1:0] i_gpio_rdata,
    output gpio_req_t         o_gpio_req,
    output read_rsp_t         o_rsp
);

    // Address fields
    logic       simple_space;
    logic [3:0] user_slot;
    logic [5:0] slot_offset;
    logic       gpio_sel;
    logic       write_req;

    // Bit 10 picks the 16-byte simple space, otherwise bits 9:6 pick a 64-byte user slot
    assign simple_space = i_req.addr[10];
    assign user_slot    = i_req.addr[9:6];
    assign slot_offset  = i_req.addr[5:0];

    assign gpio_sel  = !simple_space && (user_slot == 4'(GPIO_SLOT));
    assign write_req = (i_req.write_size != ACC_NONE);

    // GPIO only ever sees writes aimed at its own slot
    always_comb begin
        o_gpio_req.offset = slot_offset;
        o_gpio_req.wdata  = i_req.wdata[7:0];
        o_gpio_req.wr     = gpio_sel && write_req;
    end

    // Read response of the addressed slot
    always_comb begin
        o_rsp.data  = '0;
        o_rsp.ready = 1'b1;

        if (simple_space) begin
            // Simple space is empty
            o_rsp.data = '0;
        end else begin
            case (user_slot)
                4'(GPIO_SLOT): begin
                    o_rsp.data = i_gpio_rdata;
                end
                default: begin
                    // Unpopulated user slot, reads zero but never stalls
                    o_rsp.data = '0;
                end
            endcase
        end
    end

endmodule

//--- logic/periph_pkg.sv
// Bus widths, slot and offset constants, access-size and read-state enums, bus structs
package periph_pkg;

    // Bus and pin widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int PIN_W  = 8;
    localparam int FSEL_W = 5;

    // User slot numbers
    localparam int GPIO_SLOT = 1;
    // UART is gone, but pins 0 and 1 still reset to its slot
    localparam int UART_SLOT = 2;

    // GPIO register offsets within the 64-byte slot
    localparam logic [5:0] GPIO_OUT_OFS = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS  = 6'h04;
    localparam logic [5:0] FSEL_BASE    = 6'h20;

    // Core access size, all ones means no access
    typedef enum logic [1:0] {
        ACC_8    = 2'b00,
        ACC_16   = 2'b01,
        ACC_32   = 2'b10,
        ACC_NONE = 2'b11
    } access_size_e;

    typedef enum logic {
        RD_IDLE,
        RD_HOLD
    } read_state_e;

    // Request from the core as seen by the decoder
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        access_size_e      write_size;
        access_size_e      read_size;
    } bus_req_t;

    // Slot-local request into the GPIO block
    typedef struct packed {
        logic [5:0] offset;
        logic [7:0] wdata;
        logic       wr;
    } gpio_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              ready;
    } read_rsp_t;

endpackage

//--- logic/read_return_fsm.sv
// Read return FSM with captured data, registered ready and hold until read completion
module read_return_fsm
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  read_rsp_t         i_rsp,
    input  access_size_e      i_read_size,
    input  access_size_e      i_write_size,
    input  logic              i_read_complete,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready
);

    read_state_e       state_q;
    logic [DATA_W-1:0] data_q;
    logic              ready_q;

    logic read_req;
    logic write_req;
    logic capture;

    assign read_req  = (i_read_size != ACC_NONE);
    assign write_req = (i_write_size != ACC_NONE);

    // Only the first ready cycle of a read loads the data
    assign capture = (state_q == RD_IDLE) && read_req && i_rsp.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
            ready_q <= 1'b0;
        end else begin
            // Ready lags the response by one cycle to line up with data_q
            ready_q <= read_req && i_rsp.ready;

            case (state_q)
                RD_IDLE: if (capture) state_q <= RD_HOLD;
                RD_HOLD: if (i_read_complete) state_q <= RD_IDLE;
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rsp.data;
        end
    end

    assign o_data_out = data_q;
    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_q || write_req;

endmodule

//--- tests/periph_bus_tb.sv
// Testbench for the peripheral bus wrapper with stimulus table, checks and watchdog
module periph_bus_tb
    import periph_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ROWS     = 17;
    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT_NS = N_ROWS * 20 * CLK_PERIOD;

    typedef enum logic [1:0] {
        K_WRITE,
        K_READ,
        // Read that is held while the input pins change
        K_READ_HOLD
    } kind_e;

    typedef struct packed {
        kind_e             kind;
        logic [ADDR_W-1:0] addr;
        access_size_e      size;
        logic [DATA_W-1:0] wdata;
        logic [PIN_W-1:0]  ui_in;
        logic [DATA_W-1:0] exp_rdata;
        logic [PIN_W-1:0]  exp_uo;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic [PIN_W-1:0]  ui_in;
    logic [PIN_W-1:0]  uo_out;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    access_size_e      write_size;
    access_size_e      read_size;
    logic              read_complete;
    logic [DATA_W-1:0] data_out;
    logic              data_ready;

    row_t rows [N_ROWS];

    periph_bus_top i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data               (wdata),
        .i_data_write_n       (write_size),
        .i_data_read_n        (read_size),
        .i_data_read_complete (read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test table did not finish in %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // GPIO slot 1 starts at 0x040, function selects at 0x060 + 4 * pin
    task automatic fill_table();
        rows[0]  = '{K_READ,      11'h040, ACC_32, 32'h0,         8'h00, 32'h00, 8'h00};
        rows[1]  = '{K_READ,      11'h060, ACC_32, 32'h0,         8'h00, 32'h02, 8'h00};
        rows[2]  = '{K_READ,      11'h064, ACC_32, 32'h0,         8'h00, 32'h02, 8'h00};
        rows[3]  = '{K_READ,      11'h068, ACC_32, 32'h0,         8'h00, 32'h01, 8'h00};
        rows[4]  = '{K_READ,      11'h07C, ACC_32, 32'h0,         8'h00, 32'h01, 8'h00};
        // Pins 0 and 1 still point at the removed UART
        rows[5]  = '{K_WRITE,     11'h040, ACC_8,  32'hA5A5_A5FF, 8'h00, 32'h00, 8'hFC};
        rows[6]  = '{K_READ,      11'h040, ACC_32, 32'h0,         8'h00, 32'hFF, 8'hFC};
        rows[7]  = '{K_READ,      11'h044, ACC_32, 32'h0,         8'hA5, 32'hA5, 8'hFC};
        // Bit 4 set selects the empty simple space
        rows[8]  = '{K_WRITE,     11'h060, ACC_8,  32'h0000_00FF, 8'hA5, 32'h00, 8'hFC};
        rows[9]  = '{K_READ,      11'h060, ACC_32, 32'h0,         8'hA5, 32'h1F, 8'hFC};
        // Bit 4 wins over a GPIO slot number in the low bits
        rows[10] = '{K_WRITE,     11'h060, ACC_8,  32'h0000_0011, 8'hA5, 32'h00, 8'hFC};
        rows[11] = '{K_WRITE,     11'h060, ACC_8,  32'h0000_0001, 8'hA5, 32'h00, 8'hFD};
        // Slot 5, simple space over the GPIO slot field and a write to slot 4
        rows[12] = '{K_READ,      11'h140, ACC_32, 32'h0,         8'hA5, 32'h00, 8'hFD};
        rows[13] = '{K_READ,      11'h444, ACC_32, 32'h0,         8'hA5, 32'h00, 8'hFD};
        rows[14] = '{K_WRITE,     11'h100, ACC_32, 32'h0000_0000, 8'hA5, 32'h00, 8'hFD};
        rows[15] = '{K_READ,      11'h040, ACC_32, 32'h0,         8'hA5, 32'hFF, 8'hFD};
        rows[16] = '{K_READ_HOLD, 11'h044, ACC_32, 32'h0,         8'h5A, 32'h5A, 8'hFD};
    endtask

    task automatic apply_write(input row_t row, input int idx);
        @(posedge clk);
        addr       <= row.addr;
        wdata      <= row.wdata;
        ui_in      <= row.ui_in;
        write_size <= row.size;
        read_size  <= ACC_NONE;
        // Writes complete in the request cycle itself
        @(negedge clk);
        check_value($sformatf("o_data_ready row %0d", idx), 32'(data_ready), 32'h1);
        @(posedge clk);
        write_size <= ACC_NONE;
        @(negedge clk);
        check_value($sformatf("o_uo_out row %0d", idx), 32'(uo_out), 32'(row.exp_uo));
    endtask

    task automatic apply_read(input row_t row, input int idx);
        @(posedge clk);
        addr       <= row.addr;
        ui_in      <= row.ui_in;
        write_size <= ACC_NONE;
        read_size  <= row.size;
        @(negedge clk);
        check_value($sformatf("o_data_ready row %0d", idx), 32'(data_ready), 32'h0);
        @(negedge clk);
        if (!data_ready) begin
            $display("Read of address 0x%03h got no ready one cycle after the request",
                     row.addr);
            $display("Simulation failed");
            $fatal(1);
        end
        check_value($sformatf("o_data_out row %0d", idx), data_out, row.exp_rdata);
        if (row.kind == K_READ_HOLD) begin
            // Pins move while the core delays completion
            @(posedge clk);
            ui_in <= ~row.ui_in;
            repeat (2) @(negedge clk);
            check_value($sformatf("o_data_out held row %0d", idx), data_out, row.exp_rdata);
            check_value($sformatf("o_data_ready held row %0d", idx), 32'(data_ready), 32'h1);
        end
        @(posedge clk);
        read_size     <= ACC_NONE;
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
        @(negedge clk);
        check_value($sformatf("o_uo_out row %0d", idx), 32'(uo_out), 32'(row.exp_uo));
    endtask

    initial begin
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_size    = ACC_NONE;
        read_size     = ACC_NONE;
        read_complete = 1'b0;
        fill_table();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].kind == K_WRITE) begin
                apply_write(rows[i], i);
            end else begin
                apply_read(rows[i], i);
            end
        end

        @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule
